//--- axi_rd_pkg.sv
// Shared widths, field types and encodings for the AXI read subordinate
// Imported by every design file that names a bus field or a state
package axi_rd_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    // Byte offset bits inside one data word
    localparam int unsigned BYTE_W = $clog2(DATA_W / 8);
    localparam int unsigned ID_W   = 4;
    // Packed response beat: data, id, resp code, last flag
    localparam int unsigned BEAT_W = DATA_W + ID_W + 2 + 1;

    // ------------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------------
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    // Beats minus one
    typedef logic [7:0]        len_t;
    // Beat bytes as a power of two
    typedef logic [2:0]        size_t;

    // AXI burst types, RESERVED behaves as FIXED
    typedef enum logic [1:0] {
        BURST_FIXED    = 2'b00,
        BURST_INCR     = 2'b01,
        BURST_WRAP     = 2'b10,
        BURST_RESERVED = 2'b11
    } burst_e;

    // AXI response codes, only OKAY and SLVERR are produced here
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Request side control FSM
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_BURST = 1'b1
    } ctrl_state_e;

endpackage

//--- axi_rd_if.sv
// One returned read beat with its context, between the datapath blocks
// The context pipeline drives valid, id and last, the top level drives
// data and err from the component; there is no back-pressure
`timescale 1ns/10ps

interface rd_beat_if;
    import axi_rd_pkg::*;

    // Beat present this cycle, taken unconditionally
    logic  valid;
    // Transaction id of the burst this beat belongs to
    id_t   id;
    // Final beat of the burst
    logic  last;
    // Read data from the component
    data_t data;
    // Component error for this beat
    logic  err;

    // Context pipeline side
    modport src (
        output valid,
        output id,
        output last
    );

    // Response pipeline side
    modport dst (
        input valid,
        input id,
        input last,
        input data,
        input err
    );

endinterface

//--- axi_rd_skid_buf.sv
// Single entry skid buffer with valid/ready on both sides
// Empty: the input passes straight through with no added latency
// Stalled: the beat is parked in the register and the input side sees
// ready low until the downstream takes it
`timescale 1ns/10ps

module axi_rd_skid_buf (
    input  logic                          clk,
    input  logic                          rst_n,
    // Upstream side
    input  logic                          i_valid,
    output logic                          o_ready,
    input  logic [axi_rd_pkg::BEAT_W-1:0] i_data,
    // Downstream side
    output logic                          o_valid,
    input  logic                          i_ready,
    output logic [axi_rd_pkg::BEAT_W-1:0] o_data
);

    // Parked beat present
    logic                          full;
    logic [axi_rd_pkg::BEAT_W-1:0] skid_q;

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign o_ready = !full;
    assign o_valid = full || i_valid;
    // Parked beat always goes first
    assign o_data  = full ? skid_q : i_data;

    // ------------------------------------------------------------------
    // Occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (full) begin
            // Drains when downstream accepts
            if (i_ready) begin
                full <= 1'b0;
            end
        end else if (i_valid && !i_ready) begin
            full <= 1'b1;
        end
    end

    // Capture the passing beat when downstream stalls
    always_ff @(posedge clk) begin
        if (!full && i_valid && !i_ready) begin
            skid_q <= i_data;
        end
    end

    // A stalled beat stays offered and unchanged
    out_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
    );

endmodule

//--- axi_rd_addr_gen.sv
// Next beat address for FIXED, INCR and WRAP bursts
// Purely combinational; works from the full unaligned address so narrow
// beats step through a word byte by byte
`timescale 1ns/10ps

module axi_rd_addr_gen (
    input  axi_rd_pkg::addr_t   i_cur_addr,
    input  axi_rd_pkg::size_t   i_size,
    input  axi_rd_pkg::burst_e  i_burst,
    input  axi_rd_pkg::len_t    i_len,
    output axi_rd_pkg::addr_t   o_next_addr
);
    import axi_rd_pkg::*;

    // Bytes per beat
    addr_t beat_bytes;
    // Address aligned down to the beat size
    addr_t aligned;
    // Plain increment from the aligned address
    addr_t incr_addr;
    // Wrap window size in bytes, always a power of two for WRAP
    addr_t wrap_bytes;
    addr_t wrap_mask;
    addr_t wrap_addr;

    always_comb begin
        beat_bytes = addr_t'(1) << i_size;
        aligned    = i_cur_addr & ~(beat_bytes - addr_t'(1));
        incr_addr  = aligned + beat_bytes;

        // Beats times beat bytes
        wrap_bytes = (addr_t'(i_len) + addr_t'(1)) << i_size;
        wrap_mask  = wrap_bytes - addr_t'(1);
        // Keep the window base, let the offset roll over inside it
        wrap_addr  = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);
    end

    // ------------------------------------------------------------------
    // Burst select
    // ------------------------------------------------------------------
    always_comb begin
        case (i_burst)
            BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            BURST_WRAP: begin
                o_next_addr = wrap_addr;
            end
            // FIXED and RESERVED repeat the same address
            default: begin
                o_next_addr = i_cur_addr;
            end
        endcase
    end

endmodule

//--- axi_rd_ctx_pipe.sv
// Carries the id and last flag of each issued beat alongside the component
// access, so they line up with the read data CMP_LAT cycles later
// At zero latency the context passes straight through
`timescale 1ns/10ps

module axi_rd_ctx_pipe #(
    parameter int unsigned CMP_LAT = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_issue,
    input  axi_rd_pkg::id_t  i_id,
    input  logic             i_last,
    rd_beat_if.src           beat
);
    import axi_rd_pkg::*;

    generate
        if (CMP_LAT == 0) begin : g_pass
            // Data returns in the issue cycle
            assign beat.valid = i_issue;
            assign beat.id    = i_id;
            assign beat.last  = i_last;
        end else begin : g_pipe
            // One stage per cycle of component latency
            logic [CMP_LAT-1:0] vld_sr;
            id_t                id_sr   [CMP_LAT];
            logic [CMP_LAT-1:0] last_sr;

            // Valid bits are the control path
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    vld_sr <= '0;
                end else begin
                    vld_sr[0] <= i_issue;
                    for (int k = 1; k < CMP_LAT; k++) begin
                        vld_sr[k] <= vld_sr[k-1];
                    end
                end
            end

            // Context only matters where the valid bit is set
            always_ff @(posedge clk) begin
                id_sr[0]   <= i_id;
                last_sr[0] <= i_last;
                for (int k = 1; k < CMP_LAT; k++) begin
                    id_sr[k]   <= id_sr[k-1];
                    last_sr[k] <= last_sr[k-1];
                end
            end

            assign beat.valid = vld_sr[CMP_LAT-1];
            assign beat.id    = id_sr[CMP_LAT-1];
            assign beat.last  = last_sr[CMP_LAT-1];
        end
    endgenerate

endmodule

//--- axi_rd_rsp_pipe.sv
// Turns a returned beat into an R channel beat and runs it through a
// chain of skid stages, one more than the component latency
// The ready of the last stage tells the request side there is room
`timescale 1ns/10ps

module axi_rd_rsp_pipe #(
    parameter int unsigned CMP_LAT = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    rd_beat_if.dst              beat,
    output logic                o_space,
    // R channel
    output logic                o_r_valid,
    output axi_rd_pkg::data_t   o_r_data,
    output axi_rd_pkg::id_t     o_r_id,
    output axi_rd_pkg::resp_e   o_r_resp,
    output logic                o_r_last,
    input  logic                i_r_ready
);
    import axi_rd_pkg::*;

    // Index 0 is the input side, CMP_LAT+1 is the R channel
    logic [CMP_LAT+1:0] stg_valid;
    logic [CMP_LAT+1:0] stg_ready;
    logic [BEAT_W-1:0]  stg_data [CMP_LAT+2];
    resp_e              in_resp;

    assign in_resp      = beat.err ? RESP_SLVERR : RESP_OKAY;
    assign stg_valid[0] = beat.valid;
    // Packed as data, id, resp, last
    assign stg_data[0]  = {beat.data, beat.id, in_resp, beat.last};

    generate
        for (genvar s = 0; s <= CMP_LAT; s++) begin : g_stage
            axi_rd_skid_buf stage_inst (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_valid (stg_valid[s]),
                .o_ready (stg_ready[s]),
                .i_data  (stg_data[s]),
                .o_valid (stg_valid[s+1]),
                .i_ready (stg_ready[s+1]),
                .o_data  (stg_data[s+1])
            );
        end

        // Output stages fill first and drain last
        // A full stage sits behind a full stage, or one that just drained
        for (genvar s = 0; s < CMP_LAT; s++) begin : g_order_chk
            fill_order_a: assert property (
                @(posedge clk) disable iff (!rst_n)
                !stg_ready[s] |-> (!stg_ready[s+1] || $past(!stg_ready[s+1]))
            );
        end
    endgenerate

    assign stg_ready[CMP_LAT+1] = i_r_ready;
    assign o_space              = stg_ready[CMP_LAT];

    // Unpack the beat at the R channel
    assign o_r_valid = stg_valid[CMP_LAT+1];
    assign o_r_data  = stg_data[CMP_LAT+1][BEAT_W-1 -: DATA_W];
    assign o_r_id    = stg_data[CMP_LAT+1][ID_W+2:3];
    assign o_r_resp  = resp_e'(stg_data[CMP_LAT+1][2:1]);
    assign o_r_last  = stg_data[CMP_LAT+1][0];

    // Returned data has no back-pressure, so it must always find room
    no_drop_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(stg_valid[0] && !stg_ready[0])
    );

endmodule

//--- axi_rd_ctrl.sv
// Request side of the read subordinate
// Accepts AR bursts, walks the beats and issues one aligned component
// request per beat while the response pipeline has room
`timescale 1ns/10ps

module axi_rd_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    // AR channel
    input  logic                i_ar_valid,
    output logic                o_ar_ready,
    input  axi_rd_pkg::addr_t   i_ar_addr,
    input  axi_rd_pkg::burst_e  i_ar_burst,
    input  axi_rd_pkg::size_t   i_ar_size,
    input  axi_rd_pkg::len_t    i_ar_len,
    input  axi_rd_pkg::id_t     i_ar_id,
    // Address generator
    output axi_rd_pkg::addr_t   o_cur_addr,
    output axi_rd_pkg::size_t   o_cur_size,
    output axi_rd_pkg::burst_e  o_cur_burst,
    output axi_rd_pkg::len_t    o_cur_len,
    input  axi_rd_pkg::addr_t   i_next_addr,
    // Response pipeline room
    input  logic                i_space,
    // Issue strobe and beat context toward the context pipeline
    output logic                o_issue,
    output axi_rd_pkg::id_t     o_issue_id,
    output logic                o_issue_last,
    // Component request
    output logic                o_cmp_dv,
    output axi_rd_pkg::addr_t   o_cmp_addr,
    input  logic                i_cmp_hld
);
    import axi_rd_pkg::*;

    ctrl_state_e state;
    // Beats left after the current one
    len_t        beat_cnt;
    logic        ar_fire;
    logic        final_issue;

    // ------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------
    // Ready again in the cycle of the final issued beat, so bursts overlap
    assign o_ar_ready   = (state == ST_IDLE) || final_issue;
    assign ar_fire      = i_ar_valid && o_ar_ready;

    // Only request when the last skid stage can absorb a stalled beat
    assign o_cmp_dv     = (state == ST_BURST) && i_space;
    assign o_issue      = o_cmp_dv && !i_cmp_hld;
    assign o_issue_last = (beat_cnt == '0);
    assign final_issue  = o_issue && o_issue_last;

    // Component only sees word addresses
    assign o_cmp_addr   = {o_cur_addr[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};

    // ------------------------------------------------------------------
    // FSM and beat counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else if (ar_fire) begin
            state    <= ST_BURST;
            beat_cnt <= i_ar_len;
        end else if (o_issue) begin
            // Holds at zero once the last beat has gone out
            if (beat_cnt != '0) begin
                beat_cnt <= beat_cnt - len_t'(1);
            end
            if (final_issue) begin
                state <= ST_IDLE;
            end
        end
    end

    // Burst context, the address steps on every issued beat
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            o_cur_addr  <= i_ar_addr;
            o_cur_burst <= i_ar_burst;
            o_cur_size  <= i_ar_size;
            o_cur_len   <= i_ar_len;
            o_issue_id  <= i_ar_id;
        end else if (o_issue) begin
            o_cur_addr  <= i_next_addr;
        end
    end

    // Requester must hold AR valid until it is taken
    ar_valid_hold_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_ar_valid && !o_ar_ready) |=> i_ar_valid
    );

endmodule

//--- axi_rd_sub.sv
// AXI read subordinate in front of a fixed latency component
// Plain AR and R channel ports plus the component request and return
// CMP_LAT is the cycle count from an accepted request to its read data
`timescale 1ns/10ps

module axi_rd_sub #(
    parameter int unsigned CMP_LAT = 1
) (
    input  logic                clk,
    input  logic                rst_n,
    // AR channel
    input  logic                i_ar_valid,
    input  axi_rd_pkg::addr_t   i_ar_addr,
    input  logic [1:0]          i_ar_burst,
    input  axi_rd_pkg::size_t   i_ar_size,
    input  axi_rd_pkg::len_t    i_ar_len,
    input  axi_rd_pkg::id_t     i_ar_id,
    output logic                o_ar_ready,
    // R channel
    output logic                o_r_valid,
    output axi_rd_pkg::data_t   o_r_data,
    output axi_rd_pkg::id_t     o_r_id,
    output logic [1:0]          o_r_resp,
    output logic                o_r_last,
    input  logic                i_r_ready,
    // Component
    output logic                o_cmp_dv,
    output axi_rd_pkg::addr_t   o_cmp_addr,
    input  logic                i_cmp_hld,
    input  logic                i_cmp_err,
    input  axi_rd_pkg::data_t   i_cmp_rdata
);
    import axi_rd_pkg::*;

    addr_t  cur_addr;
    size_t  cur_size;
    burst_e cur_burst;
    len_t   cur_len;
    addr_t  next_addr;
    logic   issue;
    id_t    issue_id;
    logic   issue_last;
    logic   space;

    rd_beat_if beat_if ();

    // Component return joins the delayed context here
    assign beat_if.data = i_cmp_rdata;
    assign beat_if.err  = i_cmp_err;

    axi_rd_ctrl ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ar_valid   (i_ar_valid),
        .o_ar_ready   (o_ar_ready),
        .i_ar_addr    (i_ar_addr),
        .i_ar_burst   (burst_e'(i_ar_burst)),
        .i_ar_size    (i_ar_size),
        .i_ar_len     (i_ar_len),
        .i_ar_id      (i_ar_id),
        .o_cur_addr   (cur_addr),
        .o_cur_size   (cur_size),
        .o_cur_burst  (cur_burst),
        .o_cur_len    (cur_len),
        .i_next_addr  (next_addr),
        .i_space      (space),
        .o_issue      (issue),
        .o_issue_id   (issue_id),
        .o_issue_last (issue_last),
        .o_cmp_dv     (o_cmp_dv),
        .o_cmp_addr   (o_cmp_addr),
        .i_cmp_hld    (i_cmp_hld)
    );

    axi_rd_addr_gen addr_gen_inst (
        .i_cur_addr  (cur_addr),
        .i_size      (cur_size),
        .i_burst     (cur_burst),
        .i_len       (cur_len),
        .o_next_addr (next_addr)
    );

    axi_rd_ctx_pipe #(.CMP_LAT(CMP_LAT)) ctx_pipe_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_issue (issue),
        .i_id    (issue_id),
        .i_last  (issue_last),
        .beat    (beat_if.src)
    );

    axi_rd_rsp_pipe #(.CMP_LAT(CMP_LAT)) rsp_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat      (beat_if.dst),
        .o_space   (space),
        .o_r_valid (o_r_valid),
        .o_r_data  (o_r_data),
        .o_r_id    (o_r_id),
        .o_r_resp  (o_r_resp),
        .o_r_last  (o_r_last),
        .i_r_ready (i_r_ready)
    );

endmodule

//--- tb_axi_rd_sub.sv
// Directed testbench for the AXI read subordinate
// Drives AR bursts, models a fixed latency component and collects R beats
// Expected beats come from the AXI burst address rules, computed here
`timescale 1ns/10ps

module tb_axi_rd_sub;
    import axi_rd_pkg::*;

    localparam int    CMP_LAT  = 2;
    localparam addr_t DATA_KEY = 32'hA5A5_0000;
    localparam addr_t ERR_LO   = 32'h0000_F000;
    localparam addr_t ERR_HI   = 32'h0000_F0FF;
    // 66 beats in all, about 10 cycles each, plus generous room for stalls
    localparam int    TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        rst_n;
    logic        i_ar_valid;
    addr_t       i_ar_addr;
    logic [1:0]  i_ar_burst;
    size_t       i_ar_size;
    len_t        i_ar_len;
    id_t         i_ar_id;
    logic        o_ar_ready;
    logic        o_r_valid;
    data_t       o_r_data;
    id_t         o_r_id;
    logic [1:0]  o_r_resp;
    logic        o_r_last;
    logic        i_r_ready;
    logic        o_cmp_dv;
    addr_t       o_cmp_addr;
    logic        i_cmp_hld;
    logic        i_cmp_err;
    data_t       i_cmp_rdata;

    integer      seed = 8;
    logic        stall_en;
    int          cycle_cnt;
    int          issue_cnt;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          k;

    // Component return pipe
    data_t       pipe_data [CMP_LAT];
    logic        pipe_err  [CMP_LAT];
    data_t       req_data;
    logic        req_err;

    // Expected and received beats
    data_t       exp_data[$];
    id_t         exp_id[$];
    resp_e       exp_resp[$];
    logic        exp_last[$];
    data_t       rx_data[$];
    id_t         rx_id[$];
    resp_e       rx_resp[$];
    logic        rx_last[$];

    axi_rd_sub #(.CMP_LAT(CMP_LAT)) axi_rd_sub_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ar_valid  (i_ar_valid),
        .i_ar_addr   (i_ar_addr),
        .i_ar_burst  (i_ar_burst),
        .i_ar_size   (i_ar_size),
        .i_ar_len    (i_ar_len),
        .i_ar_id     (i_ar_id),
        .o_ar_ready  (o_ar_ready),
        .o_r_valid   (o_r_valid),
        .o_r_data    (o_r_data),
        .o_r_id      (o_r_id),
        .o_r_resp    (o_r_resp),
        .o_r_last    (o_r_last),
        .i_r_ready   (i_r_ready),
        .o_cmp_dv    (o_cmp_dv),
        .o_cmp_addr  (o_cmp_addr),
        .i_cmp_hld   (i_cmp_hld),
        .i_cmp_err   (i_cmp_err),
        .i_cmp_rdata (i_cmp_rdata)
    );

    // ------------------------------------------------------------------
    // Clock, timeout, stall driver
    // ------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, a test never completed", cycle_cnt);
        $display("Testbench failed");
        $finish;
    end

    // R ready low about a quarter of the time, hold about an eighth
    initial begin
        i_r_ready = 1'b1;
        i_cmp_hld = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                i_r_ready = ($random(seed) & 3) != 0;
                i_cmp_hld = ($random(seed) & 7) == 0;
            end else begin
                i_r_ready = 1'b1;
                i_cmp_hld = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Component model and R collector
    // ------------------------------------------------------------------
    // Requests sampled mid cycle, data comes back CMP_LAT cycles later
    always @(negedge clk) begin
        if (o_cmp_dv && !i_cmp_hld) begin
            req_data = o_cmp_addr ^ DATA_KEY;
            req_err  = (o_cmp_addr >= ERR_LO) && (o_cmp_addr <= ERR_HI);
            issue_cnt++;
        end else begin
            req_data = '0;
            req_err  = 1'b0;
        end
    end

    initial begin
        i_cmp_rdata = '0;
        i_cmp_err   = 1'b0;
        for (k = 0; k < CMP_LAT; k++) begin
            pipe_data[k] = '0;
            pipe_err[k]  = 1'b0;
        end
        forever begin
            @(posedge clk);
            #1;
            for (k = CMP_LAT - 1; k > 0; k--) begin
                pipe_data[k] = pipe_data[k-1];
                pipe_err[k]  = pipe_err[k-1];
            end
            pipe_data[0] = req_data;
            pipe_err[0]  = req_err;
            i_cmp_rdata  = pipe_data[CMP_LAT-1];
            i_cmp_err    = pipe_err[CMP_LAT-1];
        end
    end

    always @(negedge clk) begin
        if (rst_n && o_r_valid && i_r_ready) begin
            rx_data.push_back(o_r_data);
            rx_id.push_back(o_r_id);
            rx_resp.push_back(resp_e'(o_r_resp));
            rx_last.push_back(o_r_last);
        end
    end

    // ------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------
    // Address of a beat, straight from the AXI burst rules
    function automatic addr_t beat_addr(addr_t start, burst_e burst, size_t size,
                                        len_t len, int beat);
        addr_t bytes;
        addr_t lo;
        addr_t win;
        addr_t base;
        bytes = addr_t'(1) << size;
        lo    = start & ~(bytes - addr_t'(1));
        if (beat == 0 || burst == BURST_FIXED || burst == BURST_RESERVED) begin
            return start;
        end
        if (burst == BURST_INCR) begin
            return lo + addr_t'(beat) * bytes;
        end
        // WRAP window is beats times beat bytes, aligned to its size
        win  = (addr_t'(len) + addr_t'(1)) * bytes;
        base = start - (start % win);
        return base + ((lo - base + addr_t'(beat) * bytes) % win);
    endfunction

    task automatic expect_burst(addr_t start, burst_e burst, size_t size, len_t len, id_t id);
        addr_t word;
        int    i;
        for (i = 0; i <= int'(len); i++) begin
            word = beat_addr(start, burst, size, len, i);
            word = (word >> BYTE_W) << BYTE_W;
            exp_data.push_back(word ^ DATA_KEY);
            exp_id.push_back(id);
            exp_resp.push_back((word >= ERR_LO && word <= ERR_HI) ? RESP_SLVERR : RESP_OKAY);
            exp_last.push_back(i == int'(len));
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_id(string name, id_t exp, id_t got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_resp(string name, resp_e exp, resp_e got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_last(string name, logic exp, logic got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequencing
    // ------------------------------------------------------------------
    task automatic start_test();
        exp_data.delete();
        exp_id.delete();
        exp_resp.delete();
        exp_last.delete();
        rx_data.delete();
        rx_id.delete();
        rx_resp.delete();
        rx_last.delete();
        issue_cnt = 0;
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_ar(addr_t addr, burst_e burst, size_t size, len_t len, id_t id);
        i_ar_valid = 1'b1;
        i_ar_addr  = addr;
        i_ar_burst = burst;
        i_ar_size  = size;
        i_ar_len   = len;
        i_ar_id    = id;
        @(negedge clk);
        while (!o_ar_ready) @(negedge clk);
        @(posedge clk);
        #1;
        i_ar_valid = 1'b0;
    endtask

    task automatic finish_test(string name);
        int errs_before;
        int n;
        int i;
        errs_before = err_cnt;
        n = exp_data.size();
        while (rx_data.size() < n) @(posedge clk);
        // Nothing may be left behind the final beat
        @(negedge clk);
        if (o_r_valid) begin
            $display("%s: extra R beat offered after the last expected beat", name);
            err_cnt++;
        end
        @(posedge clk);
        #1;
        if (rx_data.size() != n || issue_cnt != n) begin
            $display("%s: expected %0d beats, got %0d beats from %0d component requests",
                     name, n, rx_data.size(), issue_cnt);
            err_cnt++;
        end
        for (i = 0; i < n && i < rx_data.size(); i++) begin
            check_data($sformatf("o_r_data beat %0d", i), exp_data[i], rx_data[i]);
            check_id($sformatf("o_r_id beat %0d", i), exp_id[i], rx_id[i]);
            check_resp($sformatf("o_r_resp beat %0d", i), exp_resp[i], rx_resp[i]);
            check_last($sformatf("o_r_last beat %0d", i), exp_last[i], rx_last[i]);
        end
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: %0d beats, ok", name, n);
        end else begin
            fail_cnt++;
            $display("%s: %0d beats, %0d errors", name, n, err_cnt - errs_before);
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_incr_words();
        start_test();
        expect_burst(32'h0000_1000, BURST_INCR, 3'd2, 8'd7, 4'h3);
        send_ar(32'h0000_1000, BURST_INCR, 3'd2, 8'd7, 4'h3);
        finish_test("incr_words");
    endtask

    task automatic test_fixed();
        start_test();
        expect_burst(32'h0000_2004, BURST_FIXED, 3'd2, 8'd3, 4'h7);
        send_ar(32'h0000_2004, BURST_FIXED, 3'd2, 8'd3, 4'h7);
        finish_test("fixed");
    endtask

    // Starts at word 2 of the window at 0x100
    task automatic test_wrap();
        start_test();
        expect_burst(32'h0000_0108, BURST_WRAP, 3'd2, 8'd3, 4'hA);
        send_ar(32'h0000_0108, BURST_WRAP, 3'd2, 8'd3, 4'hA);
        finish_test("wrap");
    endtask

    task automatic test_backpressure();
        start_test();
        stall_en = 1'b1;
        expect_burst(32'h0000_0400, BURST_INCR, 3'd2, 8'd15, 4'h5);
        expect_burst(32'h0000_0800, BURST_INCR, 3'd2, 8'd11, 4'h9);
        send_ar(32'h0000_0400, BURST_INCR, 3'd2, 8'd15, 4'h5);
        send_ar(32'h0000_0800, BURST_INCR, 3'd2, 8'd11, 4'h9);
        finish_test("backpressure");
        stall_en = 1'b0;
    endtask

    // One burst runs into the error range, one runs out of it
    task automatic test_slverr();
        start_test();
        expect_burst(32'h0000_EFF0, BURST_INCR, 3'd2, 8'd7, 4'h1);
        expect_burst(32'h0000_F0F0, BURST_INCR, 3'd2, 8'd7, 4'h2);
        send_ar(32'h0000_EFF0, BURST_INCR, 3'd2, 8'd7, 4'h1);
        send_ar(32'h0000_F0F0, BURST_INCR, 3'd2, 8'd7, 4'h2);
        finish_test("slverr");
    endtask

    task automatic test_byte_beats();
        start_test();
        expect_burst(32'h0000_0201, BURST_INCR, 3'd0, 8'd5, 4'hC);
        send_ar(32'h0000_0201, BURST_INCR, 3'd0, 8'd5, 4'hC);
        finish_test("byte_beats");
    endtask

    initial begin
        rst_n      = 1'b0;
        i_ar_valid = 1'b0;
        i_ar_addr  = '0;
        i_ar_burst = 2'b00;
        i_ar_size  = '0;
        i_ar_len   = '0;
        i_ar_id    = '0;
        stall_en   = 1'b0;
        issue_cnt  = 0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        test_incr_words();
        test_fixed();
        test_wrap();
        test_backpressure();
        test_slverr();
        test_byte_beats();
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
axi_rd_pkg.sv
axi_rd_if.sv
axi_rd_skid_buf.sv
axi_rd_addr_gen.sv
axi_rd_ctx_pipe.sv
axi_rd_rsp_pipe.sv
axi_rd_ctrl.sv
axi_rd_sub.sv
tb_axi_rd_sub.sv

//--- run.sh
#!/bin/sh
# Build and run the read subordinate testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_axi_rd_sub -f tb.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
